/* bench/mbus_stimulus.txt */
// gap_cycles byte_hex expected_falling_edges
// gap is CLK_IN cycles of idle before tx_start, zero means back to back
5 00 44
0 ff 44
20 a5 44
0 5a 44
3 01 44
0 02 44
0 04 44
10 08 44
0 10 44
0 20 44
0 40 44
7 80 44

/* filelist.f */
+incdir+rtl
rtl/mbus_pkg.sv
rtl/mbus_mediator.sv
rtl/mbus_tx_node.sv
rtl/mbus_rx_node.sv
rtl/mbus_system.sv
bench/mbus_assertions.sv
bench/mbus_tb.sv

/* Makefile */
TOP := mbus_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/mbus_tb.sv */
`timescale 1ns/1ps
`include "mbus_cfg.svh"

module mbus_tb;

	localparam int FRAME_EDGES = 2 + 4 * `MBUS_DATA_BITS + 3 + `MBUS_RESET_CYCLES;
	localparam int BUSY_POKE_DELAY = 50;         // Cycles into a message before the ignored start

	logic CLK_IN = 1'b0;
	logic RESET;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_busy;
	logic rx_valid;
	logic [7:0] rx_data;
	logic bus_clk;

	int msg_gap[$];
	logic [7:0] msg_byte[$];
	int msg_edges[$];
	int watchdog_cycles = 0;
	int fall_count = 0;
	int valid_count = 0;
	logic [7:0] rx_last = 8'h00;
	logic bus_clk_prev = 1'b1;

	mbus_system dut
	(
		.CLK_IN   (CLK_IN),
		.RESET    (RESET),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.bus_clk  (bus_clk)
	);

	always #50 CLK_IN = ~CLK_IN;                 // 100 ns period

	// ##############################
	// Bus monitor
	// ##############################

	always @(negedge CLK_IN)
	begin
		bus_clk_prev <= bus_clk;
		if (bus_clk_prev && !bus_clk)
			fall_count <= fall_count + 1;
		if (rx_valid)
		begin
			valid_count <= valid_count + 1;
			rx_last <= rx_data;                  // Byte delivered with the strobe
		end
	end

	always @(negedge CLK_IN)
	begin
		if (dut.u_assertions.fail_count != 0)
			abort_run("a bound assertion on the bus signals failed");
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			abort_run("a DUT output did not match its expected value");
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int gap;
		int edges;
		logic [7:0] value;
		logic [8*128-1:0] line_buf;
		fd = $fopen("bench/mbus_stimulus.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file bench/mbus_stimulus.txt");
		while (!$feof(fd))
		begin
			line_buf = '0;
			if ($fgets(line_buf, fd) != 0)
			begin
				// Comment and blank lines do not scan
				if ($sscanf(line_buf, "%d %h %d", gap, value, edges) == 3)
				begin
					msg_gap.push_back(gap);
					msg_byte.push_back(value);
					msg_edges.push_back(edges);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic send_message(input int gap, input logic [7:0] value, input int edges);
		int fall_start;
		int valid_start;
		fall_start = fall_count;
		valid_start = valid_count;
		check_value("expected_edges", edges, FRAME_EDGES);

		repeat (gap) @(posedge CLK_IN);
		@(posedge CLK_IN);
		tx_start <= 1'b1;
		tx_data <= value;
		@(posedge CLK_IN);
		tx_start <= 1'b0;
		@(negedge CLK_IN);
		check_value("tx_busy", 32'(tx_busy), 1);

		// Start while busy must be dropped
		repeat (BUSY_POKE_DELAY) @(negedge CLK_IN);
		check_value("tx_busy", 32'(tx_busy), 1);
		@(posedge CLK_IN);
		tx_start <= 1'b1;
		tx_data <= ~value;
		@(posedge CLK_IN);
		tx_start <= 1'b0;

		do
			@(negedge CLK_IN);
		while (tx_busy);

		check_value("bus_clk falling edges", fall_count - fall_start, edges);
		check_value("rx_valid pulses", valid_count - valid_start, 1);
		check_value("rx_data", 32'(rx_last), 32'(value));
		check_value("bus_clk", 32'(bus_clk), 1);
	endtask

	// ##############################
	// Watchdog
	// ##############################

	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge CLK_IN);
		abort_run("bus hung: the watchdog expired before all messages were delivered");
	end

	initial
	begin
		RESET = 1'b0;
		tx_start = 1'b0;
		tx_data = 8'h00;
		load_stimulus();
		if (msg_byte.size() == 0)
			abort_run("the stimulus file holds no messages");
		watchdog_cycles = msg_byte.size() * 200 * `MBUS_CLK_DIVIDOR + 1000;

		repeat (10) @(posedge CLK_IN);
		RESET <= 1'b1;
		@(negedge CLK_IN);
		check_value("bus_clk", 32'(bus_clk), 1);
		check_value("tx_busy", 32'(tx_busy), 0);
		check_value("rx_valid", 32'(rx_valid), 0);

		foreach (msg_byte[i])
			send_message(msg_gap[i], msg_byte[i], msg_edges[i]);

		if (dut.u_assertions.fail_count != 0)
			abort_run("a bound assertion on the bus signals failed");
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* bench/mbus_assertions.sv */
`timescale 1ns/1ps

module mbus_assertions
(
	input logic CLK_IN,
	input logic RESET,
	input logic bus_clk,
	input logic tx_busy,
	input logic rx_valid,
	input logic rx_dout,
	input logic rx_din
);

	int fail_count = 0;                          // Failed assertion count

	a_rx_valid_pulse: assert property (@(posedge CLK_IN) disable iff (!RESET)
		rx_valid |=> !rx_valid)
		else
		begin
			$error("rx_valid stayed high for more than one cycle");
			fail_count = fail_count + 1;
		end

	// No message in flight, bus clock parked high
	a_clk_idle_high: assert property (@(posedge CLK_IN) disable iff (!RESET)
		!tx_busy |-> bus_clk)
		else
		begin
			$error("bus_clk went low while tx_busy was low");
			fail_count = fail_count + 1;
		end

	a_rx_pass: assert property (@(posedge CLK_IN) disable iff (!RESET)
		rx_dout == rx_din)
		else
		begin
			$error("receiver output differs from its ring input");
			fail_count = fail_count + 1;
		end

endmodule

bind mbus_system mbus_assertions u_assertions
(
	.CLK_IN   (CLK_IN),
	.RESET    (RESET),
	.bus_clk  (bus_clk),
	.tx_busy  (tx_busy),
	.rx_valid (rx_valid),
	.rx_dout  (rx_dout),
	.rx_din   (tx_dout)
);

/* rtl/mbus_system.sv */
`timescale 1ns/1ps

module mbus_system
(
	input  logic       CLK_IN,
	input  logic       RESET,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx_busy,
	output logic       rx_valid,
	output logic [7:0] rx_data,
	output logic       bus_clk
);

	// ##############################
	// Ring: mediator -> tx -> rx -> mediator
	// ##############################

	logic med_dout;
	logic tx_dout;
	logic rx_dout;

	mbus_mediator u_mediator
	(
		.CLK_IN  (CLK_IN),
		.RESET   (RESET),
		.din     (rx_dout),
		.dout    (med_dout),
		.bus_clk (bus_clk)
	);

	mbus_tx_node u_tx
	(
		.CLK_IN   (CLK_IN),
		.RESET    (RESET),
		.din      (med_dout),
		.bus_clk  (bus_clk),
		.dout     (tx_dout),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy)
	);

	mbus_rx_node u_rx
	(
		.CLK_IN   (CLK_IN),
		.RESET    (RESET),
		.din      (tx_dout),
		.bus_clk  (bus_clk),
		.dout     (rx_dout),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

endmodule

/* rtl/mbus_rx_node.sv */
`timescale 1ns/1ps
`include "mbus_cfg.svh"

module mbus_rx_node
(
	input  logic       CLK_IN,
	input  logic       RESET,
	input  logic       din,
	input  logic       bus_clk,
	output logic       dout,
	output logic       rx_valid,
	output logic [7:0] rx_data
);

	import mbus_pkg::*;

	localparam int IDLE_W = $clog2(`MBUS_IDLE_DETECT + 1);
	localparam int MSB = `MBUS_DATA_BITS - 1;

	mbus_rx_state_t state;
	logic bus_clk_prev;
	logic [IDLE_W-1:0] idle_cnt;
	logic [1:0] skip_cnt;                         // Rising edges to let pass
	logic first_bit;
	logic [`MBUS_DATA_BITS-1:0] rx_shift;
	logic clk_rise;
	logic bus_idle;
	logic sample;

	assign dout = din;                            // Ring passes straight through
	assign rx_data = rx_shift;
	assign clk_rise = bus_clk & ~bus_clk_prev;
	assign bus_idle = (idle_cnt == IDLE_W'(`MBUS_IDLE_DETECT));
	assign sample = clk_rise && (skip_cnt == 2'd0);

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			bus_clk_prev <= 1'b1;
			idle_cnt <= '0;
			state <= RX_IDLE;
			skip_cnt <= 2'd0;
			rx_valid <= 1'b0;
		end
		else
		begin
			bus_clk_prev <= bus_clk;
			rx_valid <= 1'b0;
			if (!bus_clk)
				idle_cnt <= '0;
			else if (!bus_idle)
				idle_cnt <= idle_cnt + 1'b1;

			if (clk_rise && skip_cnt != 2'd0)
				skip_cnt <= skip_cnt - 1'b1;

			case (state)
				RX_IDLE:
					if (bus_idle && !din)
					begin
						skip_cnt <= 2'd2;         // Arbitration and first drive edge
						state <= RX_FIRST;
					end
				RX_FIRST:
					if (sample)
					begin
						skip_cnt <= 2'd1;
						state <= RX_SECOND;
					end
				RX_SECOND:
					if (sample)
					begin
						if (din == first_bit)
						begin
							skip_cnt <= 2'd1;
							state <= RX_FIRST;
						end
						else
						begin
							rx_valid <= 1'b1;     // End pair
							state <= RX_WAIT_IDLE;
						end
					end
				RX_WAIT_IDLE:
					if (bus_idle)
						state <= RX_IDLE;
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge CLK_IN)
	begin
		if (sample && state == RX_FIRST)
			first_bit <= din;
		else if (sample && state == RX_SECOND && din == first_bit)
			rx_shift <= {rx_shift[MSB-1:0], din};
	end

endmodule

/* rtl/mbus_tx_node.sv */
`timescale 1ns/1ps
`include "mbus_cfg.svh"

module mbus_tx_node
(
	input  logic       CLK_IN,
	input  logic       RESET,
	input  logic       din,
	input  logic       bus_clk,
	output logic       dout,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx_busy
);

	import mbus_pkg::*;

	localparam int IDLE_W = $clog2(`MBUS_IDLE_DETECT + 1);
	localparam int SLOTS = 2 * `MBUS_DATA_BITS;          // Drive slots carrying payload
	localparam int SLOT_W = $clog2(SLOTS + 2);
	localparam int MSB = `MBUS_DATA_BITS - 1;

	mbus_tx_state_t state;
	logic bus_clk_prev;
	logic [IDLE_W-1:0] idle_cnt;
	logic [SLOT_W-1:0] slot_cnt;
	logic skip_edge;                                     // Next rising edge is a latch edge
	logic [`MBUS_DATA_BITS-1:0] tx_shift;
	logic clk_rise;
	logic bus_idle;

	assign clk_rise = bus_clk & ~bus_clk_prev;
	assign bus_idle = (idle_cnt == IDLE_W'(`MBUS_IDLE_DETECT));

	// Counts steady-high bus clock, saturating
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			bus_clk_prev <= 1'b1;
			idle_cnt <= '0;
		end
		else
		begin
			bus_clk_prev <= bus_clk;
			if (!bus_clk)
				idle_cnt <= '0;
			else if (!bus_idle)
				idle_cnt <= idle_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= TX_IDLE;
			dout <= 1'b1;
			tx_busy <= 1'b0;
			slot_cnt <= '0;
			skip_edge <= 1'b0;
			tx_shift <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					dout <= din;
					if (tx_start)
					begin
						tx_shift <= tx_data;
						tx_busy <= 1'b1;
						state <= TX_WAIT_BUS;
					end
				end

				TX_WAIT_BUS:
				begin
					dout <= din;
					if (bus_idle)
					begin
						dout <= 1'b0;             // Bus request
						skip_edge <= 1'b0;
						state <= TX_REQUEST;
					end
				end

				TX_REQUEST:
					if (clk_rise)
					begin
						if (!skip_edge)
							skip_edge <= 1'b1;    // Arbitration edge
						else
						begin
							dout <= tx_shift[MSB];
							slot_cnt <= SLOT_W'(1);
							state <= TX_SEND;
						end
					end

				TX_SEND:
					if (clk_rise)
					begin
						skip_edge <= ~skip_edge;
						if (!skip_edge)
						begin
							slot_cnt <= slot_cnt + 1'b1;
							if (slot_cnt < SLOT_W'(SLOTS))
							begin
								dout <= tx_shift[MSB];
								if (slot_cnt[0])
									tx_shift <= {tx_shift[MSB-1:0], 1'b0};
							end
							else if (slot_cnt == SLOT_W'(SLOTS))
								dout <= 1'b1;     // End pair, first slot
							else
							begin
								dout <= 1'b0;     // End pair, second slot
								state <= TX_END;
							end
						end
					end

				TX_END:
					if (clk_rise)
					begin
						dout <= 1'b1;             // Release so the ring settles high
						state <= TX_WAIT_IDLE;
					end

				TX_WAIT_IDLE:
				begin
					dout <= din;
					if (bus_idle)
					begin
						tx_busy <= 1'b0;
						state <= TX_IDLE;
					end
				end

				default:
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

/* rtl/mbus_mediator.sv */
`timescale 1ns/1ps
`include "mbus_cfg.svh"

module mbus_mediator
(
	input  logic CLK_IN,
	input  logic RESET,
	input  logic din,
	output logic dout,
	output logic bus_clk
);

	import mbus_pkg::*;

	localparam int CLK_CNT_W = $clog2(`MBUS_CLK_DIVIDOR);
	localparam int PHASE_MAX = (`MBUS_RESET_CYCLES > `MBUS_START_HALF_CYCLES) ?
		`MBUS_RESET_CYCLES : `MBUS_START_HALF_CYCLES;
	localparam int PHASE_CNT_W = $clog2(PHASE_MAX);

	mbus_med_state_t state, next_state;
	logic [CLK_CNT_W-1:0] clk_cnt, next_clk_cnt;
	logic [PHASE_CNT_W-1:0] phase_cnt, next_phase_cnt;   // Start and reset half periods left
	logic [1:0] sample_buf, next_sample_buf;
	logic clk_run, next_clk_run;
	logic half_done;
	logic pair_mismatch;

	assign half_done = (clk_cnt == '0);
	assign pair_mismatch = sample_buf[0] ^ sample_buf[1];

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= BUS_IDLE;
			clk_cnt <= CLK_CNT_W'(`MBUS_CLK_DIVIDOR - 1);
			clk_run <= 1'b0;
			sample_buf <= 2'b00;
			phase_cnt <= PHASE_CNT_W'(`MBUS_RESET_CYCLES - 1);
		end
		else
		begin
			state <= next_state;
			clk_cnt <= next_clk_cnt;
			clk_run <= next_clk_run;
			sample_buf <= next_sample_buf;
			phase_cnt <= next_phase_cnt;
		end
	end

	// ##############################
	// Bus clock and data out
	// ##############################

	always_comb
	begin
		bus_clk = 1'b1;
		dout = din;
		case (state)
			BUS_IDLE, WAIT_FOR_START_POS, ARBI_RES_POS:
				dout = 1'b1;                    // Line held high until data phases
			WAIT_FOR_START_NEG, ARBI_RES_NEG:
			begin
				bus_clk = 1'b0;
				dout = 1'b1;
			end
			DRIVE1_NEG, LATCH1_NEG, DRIVE2_NEG, LATCH2_NEG, BUS_RESET_NEG:
				bus_clk = 1'b0;
			default:
				bus_clk = 1'b1;
		endcase
	end

	// ##############################
	// Phase sequencer
	// ##############################

	always_comb
	begin
		next_state = state;
		next_clk_cnt = clk_cnt;
		next_clk_run = clk_run;
		next_sample_buf = sample_buf;
		next_phase_cnt = phase_cnt;

		if (clk_run)
		begin
			if (half_done)
				next_clk_cnt = CLK_CNT_W'(`MBUS_CLK_DIVIDOR - 1);
			else
				next_clk_cnt = clk_cnt - 1'b1;
		end

		case (state)
			BUS_IDLE:
			begin
				next_phase_cnt = PHASE_CNT_W'(`MBUS_START_HALF_CYCLES - 1);
				if (!din)
				begin
					next_state = WAIT_FOR_START_POS;   // Request seen
					next_clk_run = 1'b1;
				end
			end

			WAIT_FOR_START_POS:
				if (half_done)
				begin
					if (phase_cnt != '0)
						next_phase_cnt = phase_cnt - 1'b1;
					else
						next_state = WAIT_FOR_START_NEG;
				end

			WAIT_FOR_START_NEG:
				if (half_done)
					next_state = ARBI_RES_POS;

			ARBI_RES_POS:
				if (half_done)
					next_state = ARBI_RES_NEG;

			ARBI_RES_NEG:
				if (half_done)
					next_state = DRIVE1_POS;

			DRIVE1_POS:
				if (half_done)
					next_state = DRIVE1_NEG;

			DRIVE1_NEG:
				if (half_done)
				begin
					next_state = LATCH1_POS;
					next_sample_buf = {sample_buf[0], din};   // First copy
				end

			LATCH1_POS:
				if (half_done)
					next_state = LATCH1_NEG;

			LATCH1_NEG:
				if (half_done)
					next_state = DRIVE2_POS;

			DRIVE2_POS:
				if (half_done)
					next_state = DRIVE2_NEG;

			DRIVE2_NEG:
				if (half_done)
				begin
					next_state = LATCH2_POS;
					next_sample_buf = {sample_buf[0], din};   // Second copy
				end

			LATCH2_POS:
			begin
				next_phase_cnt = PHASE_CNT_W'(`MBUS_RESET_CYCLES - 1);
				if (pair_mismatch)
					next_state = BUS_RESET_POS;   // End of message or error
				else if (half_done)
					next_state = LATCH2_NEG;
			end

			LATCH2_NEG:
				if (half_done)
					next_state = DRIVE1_POS;

			BUS_RESET_POS:
				if (half_done)
					next_state = BUS_RESET_NEG;

			BUS_RESET_NEG:
				if (half_done)
				begin
					if (phase_cnt != '0)
					begin
						next_phase_cnt = phase_cnt - 1'b1;
						next_state = BUS_RESET_POS;
					end
					else
					begin
						next_state = BUS_IDLE;
						next_clk_run = 1'b0;      // Divider parks at full count
					end
				end

			default:
				next_state = BUS_IDLE;
		endcase
	end

endmodule

/* rtl/mbus_pkg.sv */
package mbus_pkg;

	// Mediator phases, one per bus clock half period
	typedef enum logic [3:0] {
		BUS_IDLE,
		WAIT_FOR_START_POS,
		WAIT_FOR_START_NEG,
		ARBI_RES_POS,
		ARBI_RES_NEG,
		DRIVE1_POS,
		DRIVE1_NEG,
		LATCH1_POS,
		LATCH1_NEG,
		DRIVE2_POS,
		DRIVE2_NEG,
		LATCH2_POS,
		LATCH2_NEG,
		BUS_RESET_POS,
		BUS_RESET_NEG
	} mbus_med_state_t;

	typedef enum logic [2:0] {TX_IDLE, TX_WAIT_BUS, TX_REQUEST, TX_SEND, TX_END, TX_WAIT_IDLE}
		mbus_tx_state_t;

	typedef enum logic [1:0] {RX_IDLE, RX_FIRST, RX_SECOND, RX_WAIT_IDLE} mbus_rx_state_t;

endpackage

/* rtl/mbus_cfg.svh */
`ifndef MBUS_CFG_SVH
`define MBUS_CFG_SVH

// ##############################
// Bus timing
// ##############################

`define MBUS_CLK_DIVIDOR 10           // CLK_IN cycles per bus clock half period
`define MBUS_RESET_CYCLES 7           // Bus clock periods in a bus reset
`define MBUS_START_HALF_CYCLES 6      // Half periods of the start phase
`define MBUS_IDLE_DETECT (3 * `MBUS_CLK_DIVIDOR)

// Payload
`define MBUS_DATA_BITS 8

`endif
